//--- isa_pkg.sv
package isa_pkg;

  // ========================================
  // Register file geometry
  // ========================================
  localparam int REG_N  = 16;  // r0..r15 all general purpose here
  localparam int REG_AW = 4;   // Binary register number

  // ========================================
  // ALU operation codes
  // ========================================
  localparam int ALU_OP_W = 4;

  localparam logic [ALU_OP_W-1:0] OP_MOV = 4'd0;  // dst = src
  localparam logic [ALU_OP_W-1:0] OP_ADD = 4'd1;  // dst = dst + src
  localparam logic [ALU_OP_W-1:0] OP_SUB = 4'd2;  // dst = dst - src
  localparam logic [ALU_OP_W-1:0] OP_CMP = 4'd3;  // SUB for flags only
  localparam logic [ALU_OP_W-1:0] OP_AND = 4'd4;  // dst = dst & src
  localparam logic [ALU_OP_W-1:0] OP_BIT = 4'd5;  // AND for flags only
  localparam logic [ALU_OP_W-1:0] OP_BIC = 4'd6;  // dst = dst & ~src
  localparam logic [ALU_OP_W-1:0] OP_BIS = 4'd7;  // dst = dst | src
  localparam logic [ALU_OP_W-1:0] OP_XOR = 4'd8;  // dst = dst ^ src

  // ========================================
  // Status word {V,N,Z,C}
  // ========================================
  localparam int ST_W = 4;  // Flag count
  localparam int ST_C = 0;  // Carry
  localparam int ST_Z = 1;  // Zero
  localparam int ST_N = 2;  // Negative
  localparam int ST_V = 3;  // Signed overflow

endpackage

//--- bus_pkg.sv
package bus_pkg;

  // ========================================
  // Data widths
  // ========================================
  localparam int DATA_W = 16;  // CPU word
  localparam int BYTE_W = 8;   // One byte lane

  // One data word seen whole or split in lanes
  typedef union packed {
    logic [DATA_W-1:0]      word;  // Full word
    logic [1:0][BYTE_W-1:0] lane;  // lane[1] high byte, lane[0] low byte
  } word_bytes_u;

  // ========================================
  // Memory write masks with one bit per lane
  // ========================================
  localparam logic [1:0] WR_NONE = 2'b00;  // No write
  localparam logic [1:0] WR_LO   = 2'b01;  // Low byte at even address
  localparam logic [1:0] WR_HI   = 2'b10;  // High byte at odd address
  localparam logic [1:0] WR_WORD = 2'b11;  // Both lanes

endpackage

//--- register_file.sv
`timescale 1ns/100ps

module register_file (
  input  logic                        mclk,
  input  logic                        puc_rst,
  input  logic                        wr_en,       // Writeback port
  input  logic [isa_pkg::REG_AW-1:0]  wr_sel,
  input  logic [bus_pkg::DATA_W-1:0]  wr_data,
  input  logic                        dbg_wr,      // Debug port
  input  logic [isa_pkg::REG_AW-1:0]  dbg_sel,
  input  logic [bus_pkg::DATA_W-1:0]  dbg_din,
  input  logic [isa_pkg::REG_AW-1:0]  rd_src_sel,  // Operand reads
  input  logic [isa_pkg::REG_AW-1:0]  rd_dst_sel,
  output logic [bus_pkg::DATA_W-1:0]  rd_src,
  output logic [bus_pkg::DATA_W-1:0]  rd_dst,
  output logic [bus_pkg::DATA_W-1:0]  dbg_dout
);

  logic [bus_pkg::DATA_W-1:0] regs [isa_pkg::REG_N];  // r0..r15

  // ========================================
  // Write port
  // ========================================
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      for (int i = 0; i < isa_pkg::REG_N; i++) begin
        regs[i] <= '0;                      // All registers clear
      end
    end else if (dbg_wr) begin
      regs[dbg_sel] <= dbg_din;             // Only while pipeline empty
    end else if (wr_en) begin
      regs[wr_sel] <= wr_data;              // Result from writeback
    end
  end

  // ========================================
  // Combinational read ports
  // ========================================
  assign rd_src   = regs[rd_src_sel];       // Source operand
  assign rd_dst   = regs[rd_dst_sel];       // Destination operand
  assign dbg_dout = regs[dbg_sel];          // Debug readback

endmodule

//--- operand_stage.sv
`timescale 1ns/100ps

module operand_stage (
  input  logic                          mclk,
  input  logic                          puc_rst,
  input  logic                          inst_valid,    // Issue strobe
  input  logic [isa_pkg::ALU_OP_W-1:0]  inst_alu_op,
  input  logic                          inst_bw,
  input  logic [isa_pkg::REG_AW-1:0]    inst_src,
  input  logic [isa_pkg::REG_AW-1:0]    inst_dest,
  input  logic                          inst_src_imm,
  input  logic [bus_pkg::DATA_W-1:0]    inst_sext,
  input  logic                          inst_dst_mem,
  input  logic [bus_pkg::DATA_W-1:0]    inst_dext,
  input  logic [bus_pkg::DATA_W-1:0]    rd_src,        // Register file data
  input  logic [bus_pkg::DATA_W-1:0]    rd_dst,
  input  logic                          ex_valid,      // Younger ALU stage
  input  logic                          ex_wr_reg,
  input  logic [isa_pkg::REG_AW-1:0]    ex_dest,
  input  logic [bus_pkg::DATA_W-1:0]    ex_result,
  input  logic                          wb_valid,      // Older writeback stage
  input  logic                          wb_wr_reg,
  input  logic [isa_pkg::REG_AW-1:0]    wb_dest,
  input  logic [bus_pkg::DATA_W-1:0]    wb_result,
  output logic [isa_pkg::REG_AW-1:0]    rd_src_sel,
  output logic [isa_pkg::REG_AW-1:0]    rd_dst_sel,
  output logic                          op_valid,
  output logic [isa_pkg::ALU_OP_W-1:0]  op_alu_op,
  output logic                          op_bw,
  output logic [isa_pkg::REG_AW-1:0]    op_dest,
  output logic                          op_dst_mem,
  output logic [bus_pkg::DATA_W-1:0]    op_addr,
  output logic [bus_pkg::DATA_W-1:0]    op_src,
  output logic [bus_pkg::DATA_W-1:0]    op_dst
);

  logic                       ex_hit_src, ex_hit_dst;  // Match in ALU stage
  logic                       wb_hit_src, wb_hit_dst;  // Match in writeback
  logic [bus_pkg::DATA_W-1:0] fwd_src, fwd_dst;
  logic [bus_pkg::DATA_W-1:0] src_val;

  assign rd_src_sel = inst_src;
  assign rd_dst_sel = inst_dest;

  // ========================================
  // Forwarding where the younger result wins
  // ========================================
  assign ex_hit_src = ex_valid & ex_wr_reg & (ex_dest == inst_src);
  assign ex_hit_dst = ex_valid & ex_wr_reg & (ex_dest == inst_dest);
  assign wb_hit_src = wb_valid & wb_wr_reg & (wb_dest == inst_src);
  assign wb_hit_dst = wb_valid & wb_wr_reg & (wb_dest == inst_dest);

  assign fwd_src = ex_hit_src ? ex_result : wb_hit_src ? wb_result : rd_src;
  assign fwd_dst = ex_hit_dst ? ex_result : wb_hit_dst ? wb_result : rd_dst;
  assign src_val = inst_src_imm ? inst_sext : fwd_src;  // Immediate or register

  // ========================================
  // Pipeline registers
  // ========================================
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) op_valid <= 1'b0;
    else         op_valid <= inst_valid;
  end

  always_ff @(posedge mclk) begin
    if (inst_valid) begin
      op_alu_op  <= inst_alu_op;
      op_bw      <= inst_bw;
      op_dest    <= inst_dest;
      op_dst_mem <= inst_dst_mem;
      op_addr    <= inst_dext;                // Absolute address
      op_src     <= src_val;
      op_dst     <= fwd_dst;
    end
  end

endmodule

//--- alu_stage.sv
`timescale 1ns/100ps

module alu_stage (
  input  logic                          mclk,
  input  logic                          puc_rst,
  input  logic                          op_valid,
  input  logic [isa_pkg::ALU_OP_W-1:0]  op_alu_op,
  input  logic                          op_bw,
  input  logic [isa_pkg::REG_AW-1:0]    op_dest,
  input  logic                          op_dst_mem,
  input  logic [bus_pkg::DATA_W-1:0]    op_addr,
  input  logic [bus_pkg::DATA_W-1:0]    op_src,
  input  logic [bus_pkg::DATA_W-1:0]    op_dst,
  output logic                          ex_valid,     // Forwarding view
  output logic                          ex_wr_reg,
  output logic [isa_pkg::REG_AW-1:0]    ex_dest,
  output logic [bus_pkg::DATA_W-1:0]    ex_result,
  output logic [isa_pkg::ST_W-1:0]      ex_flags,
  output logic                          ex_flags_wr,
  output logic                          wb_valid,     // Registered for writeback
  output logic                          wb_wr_reg,
  output logic                          wb_wr_mem,
  output logic                          wb_bw,
  output logic [isa_pkg::REG_AW-1:0]    wb_dest,
  output logic [bus_pkg::DATA_W-1:0]    wb_addr,
  output logic [bus_pkg::DATA_W-1:0]    wb_result,
  output logic [isa_pkg::ST_W-1:0]      wb_flags,
  output logic                          wb_flags_wr
);

  localparam int DW = bus_pkg::DATA_W;
  localparam int BW = bus_pkg::BYTE_W;

  bus_pkg::word_bytes_u src_u, dst_u, sum_u;
  logic [DW-1:0] src_a, dst_b, addend, alu_res;
  logic [DW:0]   sum;                         // Extra bit for word carry
  logic          sub_op, no_wr, flag_wr;
  logic          carry, zero, res_msb, src_msb, dst_msb, add_msb;

  function automatic logic msb_of(input logic [DW-1:0] v, input logic bw);
    return bw ? v[BW-1] : v[DW-1];            // Sign bit of active width
  endfunction

  // ========================================
  // Operands with byte mode on low lane
  // ========================================
  assign src_u = op_src;
  assign dst_u = op_dst;
  assign src_a = op_bw ? {{BW{1'b0}}, src_u.lane[0]} : src_u.word;
  assign dst_b = op_bw ? {{BW{1'b0}}, dst_u.lane[0]} : dst_u.word;

  // SUB and CMP add the inverted source plus one
  assign sub_op = (op_alu_op == isa_pkg::OP_SUB) | (op_alu_op == isa_pkg::OP_CMP);
  assign addend = !sub_op ? src_a :
                  op_bw   ? {{BW{1'b0}}, ~src_u.lane[0]} : ~src_a;
  assign sum    = {1'b0, dst_b} + {1'b0, addend} + {{DW{1'b0}}, sub_op};
  assign sum_u  = sum[DW-1:0];
  assign carry  = op_bw ? sum[BW] : sum[DW];  // Carry out means no borrow for SUB

  always_comb begin
    case (op_alu_op)
      isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_CMP:
        alu_res = op_bw ? {{BW{1'b0}}, sum_u.lane[0]} : sum_u.word;
      isa_pkg::OP_AND, isa_pkg::OP_BIT: alu_res = src_a & dst_b;
      isa_pkg::OP_BIC:                  alu_res = ~src_a & dst_b;
      isa_pkg::OP_BIS:                  alu_res = src_a | dst_b;
      isa_pkg::OP_XOR:                  alu_res = src_a ^ dst_b;
      default:                          alu_res = src_a;  // MOV
    endcase
  end

  // ========================================
  // Status flags
  // ========================================
  assign zero    = (alu_res == '0);           // Upper byte already zero
  assign res_msb = msb_of(alu_res, op_bw);
  assign src_msb = msb_of(src_a, op_bw);
  assign dst_msb = msb_of(dst_b, op_bw);
  assign add_msb = msb_of(addend, op_bw);

  always_comb begin
    ex_flags             = '0;
    ex_flags[isa_pkg::ST_N] = res_msb;
    ex_flags[isa_pkg::ST_Z] = zero;
    ex_flags[isa_pkg::ST_C] = ~zero;          // Logic ops
    case (op_alu_op)
      isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_CMP: begin
        ex_flags[isa_pkg::ST_C] = carry;
        ex_flags[isa_pkg::ST_V] = (add_msb == dst_msb) & (res_msb != dst_msb);
      end
      isa_pkg::OP_XOR: ex_flags[isa_pkg::ST_V] = src_msb & dst_msb;  // Both negative
      default:         ex_flags[isa_pkg::ST_V] = 1'b0;
    endcase
  end

  assign flag_wr = !((op_alu_op == isa_pkg::OP_MOV) | (op_alu_op == isa_pkg::OP_BIC) |
                     (op_alu_op == isa_pkg::OP_BIS));
  assign no_wr   = (op_alu_op == isa_pkg::OP_CMP) | (op_alu_op == isa_pkg::OP_BIT);

  assign ex_valid    = op_valid;
  assign ex_wr_reg   = op_valid & ~no_wr & ~op_dst_mem;  // Memory dest skips regs
  assign ex_dest     = op_dest;
  assign ex_result   = alu_res;
  assign ex_flags_wr = op_valid & flag_wr;

  // ========================================
  // Writeback registers
  // ========================================
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      wb_valid    <= 1'b0;
      wb_wr_reg   <= 1'b0;
      wb_wr_mem   <= 1'b0;
      wb_flags_wr <= 1'b0;
    end else begin
      wb_valid    <= op_valid;
      wb_wr_reg   <= ex_wr_reg;
      wb_wr_mem   <= op_valid & ~no_wr & op_dst_mem;
      wb_flags_wr <= ex_flags_wr;
    end
  end

  always_ff @(posedge mclk) begin
    wb_bw     <= op_bw;
    wb_dest   <= op_dest;
    wb_addr   <= op_addr;
    wb_result <= alu_res;
    wb_flags  <= ex_flags;
  end

endmodule

//--- writeback_stage.sv
`timescale 1ns/100ps

module writeback_stage (
  input  logic                        mclk,
  input  logic                        puc_rst,
  input  logic                        wb_valid,
  input  logic                        wb_wr_reg,
  input  logic                        wb_wr_mem,
  input  logic                        wb_bw,
  input  logic [isa_pkg::REG_AW-1:0]  wb_dest,
  input  logic [bus_pkg::DATA_W-1:0]  wb_addr,
  input  logic [bus_pkg::DATA_W-1:0]  wb_result,
  input  logic [isa_pkg::ST_W-1:0]    wb_flags,
  input  logic                        wb_flags_wr,
  output logic                        wr_en,      // Register file write
  output logic [isa_pkg::REG_AW-1:0]  wr_sel,
  output logic [bus_pkg::DATA_W-1:0]  wr_data,
  output logic [isa_pkg::ST_W-1:0]    status,     // {V,N,Z,C}
  output logic [bus_pkg::DATA_W-1:0]  mab,        // Memory write bus
  output logic                        mb_en,
  output logic [1:0]                  mb_wr,
  output logic [bus_pkg::DATA_W-1:0]  mdb_out
);

  bus_pkg::word_bytes_u res_u;

  assign res_u = wb_result;

  // ========================================
  // Register file and status
  // ========================================
  assign wr_en   = wb_valid & wb_wr_reg;
  assign wr_sel  = wb_dest;
  assign wr_data = wb_result;

  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      status <= '0;
    end else if (wb_valid & wb_flags_wr) begin
      status <= wb_flags;                     // MOV/BIC/BIS keep old flags
    end
  end

  // ========================================
  // Memory write for one cycle per instruction
  // ========================================
  assign mb_en = wb_valid & wb_wr_mem;
  assign mab   = wb_addr;

  always_comb begin
    if (!mb_en)      mb_wr = bus_pkg::WR_NONE;
    else if (!wb_bw) mb_wr = bus_pkg::WR_WORD;  // Bit 0 ignored
    else if (wb_addr[0]) mb_wr = bus_pkg::WR_HI;  // Odd byte
    else             mb_wr = bus_pkg::WR_LO;
  end

  // Byte result shows on both lanes
  assign mdb_out = wb_bw ? {2{res_u.lane[0]}} : res_u.word;

endmodule

//--- exec_unit.sv
`timescale 1ns/100ps

module exec_unit (
  input  logic                          mclk,
  input  logic                          puc_rst,
  input  logic                          inst_valid,    // One strobe per instruction
  input  logic [isa_pkg::ALU_OP_W-1:0]  inst_alu_op,
  input  logic                          inst_bw,       // Byte width
  input  logic [isa_pkg::REG_AW-1:0]    inst_src,
  input  logic [isa_pkg::REG_AW-1:0]    inst_dest,
  input  logic                          inst_src_imm,  // Source from inst_sext
  input  logic [bus_pkg::DATA_W-1:0]    inst_sext,
  input  logic                          inst_dst_mem,  // Result to memory
  input  logic [bus_pkg::DATA_W-1:0]    inst_dext,     // Absolute address
  input  logic                          dbg_reg_wr,
  input  logic [isa_pkg::REG_AW-1:0]    dbg_reg_sel,
  input  logic [bus_pkg::DATA_W-1:0]    dbg_reg_din,
  output logic [bus_pkg::DATA_W-1:0]    dbg_reg_dout,
  output logic [isa_pkg::ST_W-1:0]      status,        // {V,N,Z,C}
  output logic [bus_pkg::DATA_W-1:0]    mab,
  output logic                          mb_en,
  output logic [1:0]                    mb_wr,
  output logic [bus_pkg::DATA_W-1:0]    mdb_out
);

  // ========================================
  // Interconnect
  // ========================================
  logic [isa_pkg::REG_AW-1:0]   rd_src_sel, rd_dst_sel, wr_sel;
  logic [bus_pkg::DATA_W-1:0]   rd_src, rd_dst, wr_data;
  logic                         wr_en;
  logic                         op_valid, op_bw, op_dst_mem;
  logic [isa_pkg::ALU_OP_W-1:0] op_alu_op;
  logic [isa_pkg::REG_AW-1:0]   op_dest;
  logic [bus_pkg::DATA_W-1:0]   op_addr, op_src, op_dst;
  logic                         ex_valid, ex_wr_reg;
  logic [isa_pkg::REG_AW-1:0]   ex_dest;
  logic [bus_pkg::DATA_W-1:0]   ex_result;
  logic                         wb_valid, wb_wr_reg, wb_wr_mem, wb_bw, wb_flags_wr;
  logic [isa_pkg::REG_AW-1:0]   wb_dest;
  logic [bus_pkg::DATA_W-1:0]   wb_addr, wb_result;
  logic [isa_pkg::ST_W-1:0]     wb_flags;

  register_file u_regs (
    .mclk, .puc_rst, .wr_en, .wr_sel, .wr_data,
    .dbg_wr     (dbg_reg_wr),                 // Debug port shares write path
    .dbg_sel    (dbg_reg_sel),
    .dbg_din    (dbg_reg_din),
    .rd_src_sel, .rd_dst_sel, .rd_src, .rd_dst,
    .dbg_dout   (dbg_reg_dout)
  );

  operand_stage u_operand (
    .mclk, .puc_rst, .inst_valid, .inst_alu_op, .inst_bw, .inst_src, .inst_dest,
    .inst_src_imm, .inst_sext, .inst_dst_mem, .inst_dext, .rd_src, .rd_dst,
    .ex_valid, .ex_wr_reg, .ex_dest, .ex_result,    // Younger forward
    .wb_valid, .wb_wr_reg, .wb_dest, .wb_result,    // Older forward
    .rd_src_sel, .rd_dst_sel, .op_valid, .op_alu_op, .op_bw, .op_dest,
    .op_dst_mem, .op_addr, .op_src, .op_dst
  );

  alu_stage u_alu (
    .mclk, .puc_rst, .op_valid, .op_alu_op, .op_bw, .op_dest, .op_dst_mem,
    .op_addr, .op_src, .op_dst, .ex_valid, .ex_wr_reg, .ex_dest, .ex_result,
    .ex_flags   (),                           // Flags reach status via writeback
    .ex_flags_wr(),
    .wb_valid, .wb_wr_reg, .wb_wr_mem, .wb_bw, .wb_dest, .wb_addr, .wb_result,
    .wb_flags, .wb_flags_wr
  );

  writeback_stage u_wb (
    .mclk, .puc_rst, .wb_valid, .wb_wr_reg, .wb_wr_mem, .wb_bw, .wb_dest,
    .wb_addr, .wb_result, .wb_flags, .wb_flags_wr,
    .wr_en, .wr_sel, .wr_data, .status,
    .mab, .mb_en, .mb_wr, .mdb_out            // Memory bus driven for one cycle
  );

endmodule

//--- tb_exec_unit.sv
`timescale 1ns/100ps

module tb_exec_unit;

  localparam int CLK_NS  = 4;
  localparam int FWD_LEN = 8;                           // Back-to-back chain length
  // Debug accesses plus instructions over all tests
  localparam int N_INST  = 2*16 + 2*18*3 + (2 + FWD_LEN) + 6*3 + 2*3;
  localparam int WDOG_NS = (N_INST*8 + 100) * CLK_NS;   // 8 cycles each plus margin

  logic                          mclk;
  logic                          puc_rst;
  logic                          inst_valid;
  logic [isa_pkg::ALU_OP_W-1:0]  inst_alu_op;
  logic                          inst_bw;
  logic [isa_pkg::REG_AW-1:0]    inst_src;
  logic [isa_pkg::REG_AW-1:0]    inst_dest;
  logic                          inst_src_imm;
  logic [bus_pkg::DATA_W-1:0]    inst_sext;
  logic                          inst_dst_mem;
  logic [bus_pkg::DATA_W-1:0]    inst_dext;
  logic                          dbg_reg_wr;
  logic [isa_pkg::REG_AW-1:0]    dbg_reg_sel;
  logic [bus_pkg::DATA_W-1:0]    dbg_reg_din;
  logic [bus_pkg::DATA_W-1:0]    dbg_reg_dout;
  logic [isa_pkg::ST_W-1:0]      status;
  logic [bus_pkg::DATA_W-1:0]    mab;
  logic                          mb_en;
  logic [1:0]                    mb_wr;
  logic [bus_pkg::DATA_W-1:0]    mdb_out;

  logic [15:0] model_regs [16];                // Expected register contents
  logic [3:0]  model_status;                   // Expected {V,N,Z,C}
  logic [31:0] lcg_state = 32'ha38c_5987;

  exec_unit u_dut (.*);

  initial mclk = 1'b0;
  always #(CLK_NS/2) mclk = ~mclk;             // 4 ns period

  initial begin
    #(WDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WDOG_NS);
    $display("Some tests failed");
    $fatal(1);
  end

  // ========================================
  // Helpers
  // ========================================
  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];                   // Upper half of the state
  endfunction

  // Reference ALU that also updates model_status
  function automatic logic [15:0] model_exec(input logic [3:0] op, input logic bw,
                                             input logic [15:0] s, input logic [15:0] d);
    logic [15:0] mask, a, b, r;
    logic [16:0] full;
    int          top;
    logic        c, v, n, z;
    mask = bw ? 16'h00ff : 16'hffff;
    top  = bw ? 7 : 15;                        // Sign bit of active width
    a    = s & mask;
    b    = d & mask;
    c    = 1'b0;
    v    = 1'b0;
    case (op)
      isa_pkg::OP_ADD:                  full = {1'b0, b} + {1'b0, a};
      isa_pkg::OP_SUB, isa_pkg::OP_CMP: full = {1'b0, b} + {1'b0, ~a & mask} + 17'd1;
      default:                          full = '0;
    endcase
    case (op)
      isa_pkg::OP_MOV:                                   r = a;
      isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_CMP: r = full[15:0] & mask;
      isa_pkg::OP_AND, isa_pkg::OP_BIT:                  r = a & b;
      isa_pkg::OP_BIC:                                   r = ~a & b;
      isa_pkg::OP_BIS:                                   r = a | b;
      default:                                           r = a ^ b;  // XOR
    endcase
    n = r[top];
    z = (r == 16'h0000);
    case (op)
      isa_pkg::OP_ADD: begin
        c = bw ? full[8] : full[16];
        v = (a[top] == b[top]) && (r[top] != b[top]);  // Sign flips on equal signs
      end
      isa_pkg::OP_SUB, isa_pkg::OP_CMP: begin
        c = bw ? full[8] : full[16];           // Set when no borrow
        v = (a[top] != b[top]) && (r[top] != b[top]);
      end
      isa_pkg::OP_AND, isa_pkg::OP_BIT: c = !z;
      isa_pkg::OP_XOR: begin
        c = !z;
        v = a[top] && b[top];                  // Both negative
      end
      default: ;
    endcase
    if (op != isa_pkg::OP_MOV && op != isa_pkg::OP_BIC && op != isa_pkg::OP_BIS)
      model_status = {v, n, z, c};
    return r;
  endfunction

  task automatic check_equal(input string name, input logic [15:0] exp,
                             input logic [15:0] act);
    assert (act === exp) else begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  task automatic dbg_write(input logic [3:0] sel, input logic [15:0] din);
    @(posedge mclk);
    dbg_reg_wr  <= 1'b1;
    dbg_reg_sel <= sel;
    dbg_reg_din <= din;
    @(posedge mclk);                           // Write lands here
    dbg_reg_wr  <= 1'b0;
    model_regs[sel] = din;
  endtask

  task automatic check_reg(input string name, input logic [3:0] sel);
    @(posedge mclk);
    dbg_reg_sel <= sel;
    #1;                                        // Combinational readback settles
    check_equal({name, " reg"}, model_regs[sel], dbg_reg_dout);
  endtask

  task automatic check_state(input string name, input logic [3:0] sel);
    check_reg(name, sel);
    check_equal({name, " status"}, {12'h000, model_status}, {12'h000, status});
  endtask

  task automatic issue(input logic [3:0] op, input logic bw, input logic [3:0] s,
                       input logic [3:0] d, input logic imm, input logic [15:0] sext,
                       input logic mem, input logic [15:0] dext);
    @(posedge mclk);
    inst_valid   <= 1'b1;
    inst_alu_op  <= op;
    inst_bw      <= bw;
    inst_src     <= s;
    inst_dest    <= d;
    inst_src_imm <= imm;
    inst_sext    <= sext;
    inst_dst_mem <= mem;
    inst_dext    <= dext;
  endtask

  task automatic idle();
    @(posedge mclk);                           // Operands registered at this edge
    inst_valid <= 1'b0;
  endtask

  // ========================================
  // Tests
  // ========================================
  task automatic dbg_test();
    for (int i = 0; i < 16; i++) begin
      dbg_write(4'(i), next_rand());
    end
    for (int i = 0; i < 16; i++) begin
      check_reg("debug_round_trip", 4'(i));
    end
  endtask

  task automatic alu_test(input string name, input logic [3:0] op, input logic bw,
                          input logic imm);
    logic [3:0]  s, d;
    logic [15:0] sext, res;
    s    = 4'(next_rand());
    d    = s + 4'(1 + next_rand() % 15);     // Never equal to s
    sext = next_rand();
    dbg_write(s, next_rand());
    dbg_write(d, next_rand());
    res = model_exec(op, bw, imm ? sext : model_regs[s], model_regs[d]);
    if (op != isa_pkg::OP_CMP && op != isa_pkg::OP_BIT)
      model_regs[d] = res;                     // CMP and BIT keep the register
    issue(op, bw, s, d, imm, sext, 1'b0, 16'h0000);
    idle();
    repeat (2) @(posedge mclk);                // Register and status land at E2
    #1;
    check_state(name, d);
  endtask

  task automatic fwd_test();
    logic [3:0]  s, d, op, prev_d;
    logic [15:0] res;
    dbg_write(4'd4, next_rand());
    dbg_write(4'd5, next_rand());
    prev_d = 4'd5;
    for (int i = 0; i < FWD_LEN; i++) begin
      s   = prev_d;                            // Previous result in ALU stage
      // Order 4,5,4,4,5,5 hits writeback alone and both stages at once
      d   = (i % 6 == 1 || i % 6 >= 4) ? 4'd5 : 4'd4;
      op  = (i % 4 == 2) ? isa_pkg::OP_XOR : isa_pkg::OP_ADD;  // XOR only when s != d
      res = model_exec(op, 1'b0, model_regs[s], model_regs[d]);
      model_regs[d] = res;
      issue(op, 1'b0, s, d, 1'b0, 16'h0000, 1'b0, 16'h0000);
      prev_d = d;
    end
    idle();
    repeat (2) @(posedge mclk);                // Drain
    check_state("forwarding", 4'd4);
    check_state("forwarding", 4'd5);
  endtask

  task automatic mem_test(input string name, input logic [3:0] op, input logic bw,
                          input logic [15:0] addr);
    logic [3:0]  s, d;
    logic [15:0] res, exp_mdb;
    logic [1:0]  exp_wr;
    logic        exp_en;
    s = 4'(next_rand());
    d = s + 4'(1 + next_rand() % 15);
    dbg_write(s, next_rand());
    dbg_write(d, next_rand());
    res     = model_exec(op, bw, model_regs[s], model_regs[d]);  // Register untouched
    exp_en  = (op != isa_pkg::OP_CMP) && (op != isa_pkg::OP_BIT);
    exp_wr  = !bw ? bus_pkg::WR_WORD : addr[0] ? bus_pkg::WR_HI : bus_pkg::WR_LO;
    exp_mdb = bw ? {res[7:0], res[7:0]} : res;  // Byte on both lanes
    issue(op, bw, s, d, 1'b0, 16'h0000, 1'b1, addr);
    idle();
    #1;
    check_equal({name, " mb_en E0"}, 16'h0000, {15'h0000, mb_en});
    @(posedge mclk);
    #1;                                        // Between E1 and E2
    check_equal({name, " mb_en"}, {15'h0000, exp_en}, {15'h0000, mb_en});
    if (exp_en) begin
      check_equal({name, " mab"}, addr, mab);
      check_equal({name, " mb_wr"}, {14'h0000, exp_wr}, {14'h0000, mb_wr});
      check_equal({name, " mdb_out"}, exp_mdb, mdb_out);
    end
    @(posedge mclk);
    #1;
    check_equal({name, " mb_en E2"}, 16'h0000, {15'h0000, mb_en});
    check_state(name, d);
  endtask

  // ========================================
  // Main sequence
  // ========================================
  initial begin
    logic [15:0] addr;
    puc_rst      = 1'b1;
    inst_valid   = 1'b0;
    inst_alu_op  = '0;
    inst_bw      = 1'b0;
    inst_src     = '0;
    inst_dest    = '0;
    inst_src_imm = 1'b0;
    inst_sext    = '0;
    inst_dst_mem = 1'b0;
    inst_dext    = '0;
    dbg_reg_wr   = 1'b0;
    dbg_reg_sel  = '0;
    dbg_reg_din  = '0;
    model_status = 4'h0;
    for (int i = 0; i < 16; i++) begin
      model_regs[i] = 16'h0000;               // Matches reset state
    end
    repeat (8) @(posedge mclk);
    puc_rst <= 1'b0;

    dbg_test();
    for (int op = 0; op < 9; op++) begin
      for (int imm = 0; imm < 2; imm++) begin
        alu_test($sformatf("word_alu op%0d imm%0d", op, imm), 4'(op), 1'b0, 1'(imm));
      end
    end
    for (int op = 0; op < 9; op++) begin
      for (int imm = 0; imm < 2; imm++) begin
        alu_test($sformatf("byte_alu op%0d imm%0d", op, imm), 4'(op), 1'b1, 1'(imm));
      end
    end
    fwd_test();
    addr = next_rand();
    mem_test("mem_mov_word", isa_pkg::OP_MOV, 1'b0, addr);  // Bit 0 ignored
    mem_test("mem_mov_even", isa_pkg::OP_MOV, 1'b1, addr & 16'hfffe);
    mem_test("mem_mov_odd", isa_pkg::OP_MOV, 1'b1, addr | 16'h0001);
    addr = next_rand();
    mem_test("mem_add_word", isa_pkg::OP_ADD, 1'b0, addr);
    mem_test("mem_add_even", isa_pkg::OP_ADD, 1'b1, addr & 16'hfffe);
    mem_test("mem_add_odd", isa_pkg::OP_ADD, 1'b1, addr | 16'h0001);
    mem_test("mem_cmp_no_write", isa_pkg::OP_CMP, 1'b0, next_rand());
    mem_test("mem_bit_no_write", isa_pkg::OP_BIT, 1'b0, next_rand());

    $display("All tests passed");
    $finish;
  end

endmodule

//--- build.f
isa_pkg.sv
bus_pkg.sv
register_file.sv
operand_stage.sv
alu_stage.sv
writeback_stage.sv
exec_unit.sv
tb_exec_unit.sv
